//--- list.f
src/mipsPkg.sv
src/regFile.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memWbStage.sv
src/hazardUnit.sv
src/mipsCore.sv
testbench/mipsCore_checker.sv
testbench/tbMipsCore.sv

//--- Bender.yml
package:
  name: mips_core

sources:
  - src/mipsPkg.sv
  - src/regFile.sv
  - src/fetchStage.sv
  - src/decodeStage.sv
  - src/executeStage.sv
  - src/memWbStage.sv
  - src/hazardUnit.sv
  - src/mipsCore.sv
  - target: simulation
    files:
      - testbench/mipsCore_checker.sv
      - testbench/tbMipsCore.sv

//--- testbench/tbMipsCore.sv
`timescale 1ns/10ps
`default_nettype none

module tbMipsCore import mipsPkg::*; ();

    logic                  clk;
    logic                  rst;
    logic                  iStall = 1'b0;
    logic                  dStall = 1'b0;
    logic                  stallOn = 1'b0;
    logic [CacheAddrW-1:0] icacheAddr;
    instr_t                icacheRdata;
    dcacheReq_t            dcacheReq;
    logic [DataW-1:0]      dcacheRdata;

    logic [31:0]           imem [32];
    logic [31:0]           dmem [64];
    logic [CacheAddrW-1:0] storeAddrLog [16];
    logic [31:0]           storeDataLog [16];
    int                    storeCount = 0;

    // Program table with one row per test
    logic [31:0]           progs [6][32];
    logic [CacheAddrW-1:0] expAddr [6][8];
    logic [31:0]           expData [6][8];
    int                    progLen [6];
    int                    expCount [6];
    logic                  stallEn [6];
    string                 testName [6];
    int                    cur = -1;
    int                    passCount = 0;
    int                    failCount = 0;

    mipsCore mipsCore_i (
        .clk           (clk),
        .rst           (rst),
        .icacheAddr_o  (icacheAddr),
        .icacheRdata_i (icacheRdata),
        .icacheStall_i (iStall),
        .dcacheReq_o   (dcacheReq),
        .dcacheRdata_i (dcacheRdata),
        .dcacheStall_i (dStall)
    );

    bind mipsCore mipsCore_checker mipsCore_checker_i (
        .clk           (clk),
        .rst           (rst),
        .icacheAddr_i  (icacheAddr_o),
        .icacheStall_i (icacheStall_i),
        .dcacheReq_i   (dcacheReq_o),
        .dcacheStall_i (dcacheStall_i)
    );

    always #2 clk = ~clk;

    // Both caches answer combinationally
    assign icacheRdata = imem[icacheAddr[4:0]];
    // Read data only for an actual load
    assign dcacheRdata = dcacheReq.ren ? dmem[dcacheReq.addr[5:0]] : 'x;

    // A store is taken only in a cycle where the core is not frozen
    always @(posedge clk) begin
        if (rst) begin
            for (int a = 0; a < 64; a++) begin
                dmem[a] <= '0;
            end
            storeCount <= 0;
        end else if (dcacheReq.wen && !iStall && !dStall) begin
            dmem[dcacheReq.addr[5:0]] <= dcacheReq.wdata;
            if (storeCount < 16) begin
                storeAddrLog[storeCount] <= dcacheReq.addr;
                storeDataLog[storeCount] <= dcacheReq.wdata;
            end
            storeCount <= storeCount + 1;
        end
    end

    // Random back-pressure on both caches
    initial begin
        void'($urandom(28213));
        forever begin
            @(posedge clk);
            if (stallOn) begin
                iStall <= ($urandom % 4) == 0;
                dStall <= ($urandom % 4) == 0;
            end else begin
                iStall <= 1'b0;
                dStall <= 1'b0;
            end
        end
    end

    function automatic logic [31:0] encR(input logic [5:0] funct, input logic [4:0] rd,
                                         input logic [4:0] rs, input logic [4:0] rt);
        return {OpRType, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rt,
                                         input logic [4:0] rs, input int imm);
        return {op, rs, rt, imm[15:0]};
    endfunction

    function automatic logic [31:0] encJ(input int index);
        return {OpJ, index[25:0]};
    endfunction

    task automatic startEntry(input string name, input logic withStalls);
        cur = cur + 1;
        testName[cur] = name;
        stallEn[cur]  = withStalls;
        progLen[cur]  = 0;
        expCount[cur] = 0;
        for (int a = 0; a < 32; a++) begin
            progs[cur][a] = '0;
        end
    endtask

    task automatic addInstr(input logic [31:0] word);
        progs[cur][progLen[cur]] = word;
        progLen[cur] = progLen[cur] + 1;
    endtask

    task automatic addStore(input int wordAddr, input logic [31:0] data);
        expAddr[cur][expCount[cur]] = wordAddr;
        expData[cur][expCount[cur]] = data;
        expCount[cur] = expCount[cur] + 1;
    endtask

    // Taken and not-taken BEQ/BNE guarding stores
    task automatic branchProgram();
        addInstr(encI(OpAddi, 1, 0, 3));
        addInstr(encI(OpAddi, 2, 0, 3));
        addInstr(encI(OpAddi, 3, 0, 9));
        addInstr(encI(OpBeq, 2, 1, 1));
        addInstr(encI(OpSw, 3, 0, 0));
        addInstr(encI(OpSw, 1, 0, 4));
        addInstr(encI(OpBne, 2, 1, 1));
        addInstr(encI(OpSw, 2, 0, 8));
        addInstr(encI(OpBne, 3, 1, 1));
        addInstr(encI(OpSw, 3, 0, 12));
        addInstr(encI(OpBeq, 3, 1, 1));
        addInstr(encI(OpSw, 3, 0, 16));
        addInstr(encJ(12));
        addStore(1, 32'h3);
        addStore(2, 32'h3);
        addStore(4, 32'h9);
    endtask

    task automatic buildTable();
        startEntry("alu", 1'b0);
        addInstr(encI(OpAddi, 1, 0, 7));
        addInstr(encI(OpAddi, 2, 0, -3));
        addInstr(encR(FnAdd, 3, 1, 2));
        addInstr(encR(FnSub, 4, 1, 2));
        addInstr(encR(FnAnd, 5, 1, 2));
        addInstr(encR(FnOr, 6, 1, 2));
        addInstr(encR(FnSlt, 7, 2, 1));
        addInstr(encI(OpAddi, 0, 0, 5));
        addInstr(encR(FnAdd, 8, 0, 1));
        addInstr(encI(OpSw, 3, 0, 0));
        addInstr(encI(OpSw, 4, 0, 4));
        addInstr(encI(OpSw, 5, 0, 8));
        addInstr(encI(OpSw, 6, 0, 12));
        addInstr(encI(OpSw, 7, 0, 16));
        addInstr(encI(OpSw, 8, 0, 20));
        addInstr(encJ(15));
        addStore(0, 32'h4);
        addStore(1, 32'hA);
        addStore(2, 32'h5);
        addStore(3, 32'hFFFF_FFFF);
        addStore(4, 32'h1);
        addStore(5, 32'h7);

        startEntry("forwarding", 1'b0);
        addInstr(encI(OpAddi, 1, 0, 5));
        addInstr(encI(OpAddi, 1, 1, 3));
        addInstr(encR(FnAdd, 2, 1, 1));
        addInstr(encI(OpAddi, 3, 0, 100));
        addInstr(encR(FnSub, 4, 2, 1));
        addInstr(encI(OpSw, 4, 0, 0));
        addInstr(encI(OpSw, 2, 0, 4));
        addInstr(encR(FnOr, 5, 3, 1));
        addInstr(encI(OpSw, 5, 3, 8));
        addInstr(encI(OpAddi, 6, 5, -8));
        addInstr(encI(OpAddi, 6, 6, 1));
        addInstr(encI(OpSw, 6, 0, 12));
        addInstr(encJ(12));
        addStore(0, 32'h8);
        addStore(1, 32'h10);
        addStore(27, 32'h6C);
        addStore(3, 32'h65);

        startEntry("load-use", 1'b0);
        addInstr(encI(OpAddi, 1, 0, 'h55));
        addInstr(encI(OpAddi, 4, 0, 'h20));
        addInstr(encI(OpSw, 1, 0, 32));
        addInstr(encI(OpLw, 2, 0, 32));
        addInstr(encR(FnAdd, 3, 2, 4));
        addInstr(encI(OpSw, 3, 0, 36));
        addInstr(encI(OpLw, 5, 0, 36));
        addInstr(encI(OpSw, 5, 0, 40));
        addInstr(encJ(8));
        addStore(8, 32'h55);
        addStore(9, 32'h75);
        addStore(10, 32'h75);

        startEntry("branch", 1'b0);
        branchProgram();

        startEntry("jump", 1'b0);
        addInstr(encI(OpAddi, 1, 0, 'h11));
        addInstr(encJ(3));
        addInstr(encI(OpSw, 1, 0, 0));
        addInstr(encI(OpSw, 1, 0, 4));
        addInstr(encI(OpAddi, 2, 1, 1));
        addInstr(encJ(7));
        addInstr(encI(OpSw, 2, 0, 8));
        addInstr(encI(OpSw, 2, 0, 12));
        addInstr(encJ(8));
        addStore(1, 32'h11);
        addStore(3, 32'h12);

        startEntry("branch with stalls", 1'b1);
        branchProgram();
    endtask

    task automatic runTest(input int t);
        int cycles;
        int errors;
        @(posedge clk);
        rst     <= 1'b1;
        stallOn <= 1'b0;
        @(posedge clk);
        for (int a = 0; a < 32; a++) begin
            imem[a] <= progs[t][a];
        end
        repeat (4) @(posedge clk);
        rst     <= 1'b0;
        stallOn <= stallEn[t];
        cycles = 0;
        errors = 0;
        while (storeCount < expCount[t] && cycles < 300) begin
            @(posedge clk);
            cycles++;
        end
        stallOn <= 1'b0;
        if (storeCount < expCount[t]) begin
            $display("Test %0d (%s) timed out: only %0d of %0d stores seen in 300 cycles",
                     t, testName[t], storeCount, expCount[t]);
            errors++;
        end else begin
            for (int k = 0; k < expCount[t]; k++) begin
                if (storeAddrLog[k] !== expAddr[t][k]) begin
                    $display("ERR test %0d store %0d: dcacheReq_o.addr expected %h, got %h",
                             t, k, expAddr[t][k], storeAddrLog[k]);
                    errors++;
                end
                if (storeDataLog[k] !== expData[t][k]) begin
                    $display("ERR test %0d store %0d: dcacheReq_o.wdata expected %h, got %h",
                             t, k, expData[t][k], storeDataLog[k]);
                    errors++;
                end
            end
        end
        if (errors == 0) begin
            passCount++;
            $display("Test %0d (%s) passed", t, testName[t]);
        end else begin
            failCount++;
            $display("Test %0d (%s) failed with %0d errors", t, testName[t], errors);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        buildTable();
        for (int t = 0; t < 6; t++) begin
            runTest(t);
        end
        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/mipsCore_checker.sv
`timescale 1ns/10ps
`default_nettype none

module mipsCore_checker import mipsPkg::*; (
    input wire logic                  clk,
    input wire logic                  rst,
    input wire logic [CacheAddrW-1:0] icacheAddr_i,
    input wire logic                  icacheStall_i,
    input wire dcacheReq_t            dcacheReq_i,
    input wire logic                  dcacheStall_i
);

    // One data access per cycle
    noReadWrite: assert property (@(posedge clk) disable iff (rst)
        !(dcacheReq_i.ren && dcacheReq_i.wen))
        else $error("data cache ren and wen high together");

    idleAfterReset: assert property (@(posedge clk)
        rst |=> !dcacheReq_i.ren && !dcacheReq_i.wen)
        else $error("data cache request active right after reset");

    // Frozen core keeps its requests steady
    icacheHold: assert property (@(posedge clk) disable iff (rst)
        icacheStall_i |=> $stable(icacheAddr_i))
        else $error("instruction cache address moved during a stall");

    dcacheHold: assert property (@(posedge clk) disable iff (rst)
        dcacheStall_i |=> $stable(dcacheReq_i))
        else $error("data cache request moved during a stall");

endmodule

`default_nettype wire

//--- src/mipsCore.sv
`timescale 1ns/10ps
`default_nettype none

module mipsCore import mipsPkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,

    output logic [CacheAddrW-1:0]      icacheAddr_o,
    input  wire instr_t                icacheRdata_i,
    input  wire logic                  icacheStall_i,

    output dcacheReq_t                 dcacheReq_o,
    input  wire logic [DataW-1:0]      dcacheRdata_i,
    input  wire logic                  dcacheStall_i
);

    pipeCtl_t            ctl;
    ifId_t               ifId;
    idEx_t               idEx;
    exMem_t              exMem;
    wbReq_t              wbReq;
    logic                redirect;
    logic [DataW-1:0]    target;
    logic [RegAddrW-1:0] rsAddr;
    logic [RegAddrW-1:0] rtAddr;
    logic [DataW-1:0]    rsData;
    logic [DataW-1:0]    rtData;

    fetchStage fetchStage_i (
        .clk          (clk),
        .rst          (rst),
        .ctl_i        (ctl),
        .redirect_i   (redirect),
        .target_i     (target),
        .instr_i      (icacheRdata_i),
        .icacheAddr_o (icacheAddr_o),
        .ifId_o       (ifId)
    );

    decodeStage decodeStage_i (
        .clk      (clk),
        .rst      (rst),
        .ctl_i    (ctl),
        .ifId_i   (ifId),
        .rsAddr_o (rsAddr),
        .rtAddr_o (rtAddr),
        .rsData_i (rsData),
        .rtData_i (rtData),
        .idEx_o   (idEx)
    );

    regFile regFile_i (
        .clk      (clk),
        .rst      (rst),
        .rsAddr_i (rsAddr),
        .rtAddr_i (rtAddr),
        .wb_i     (wbReq),
        .rsData_o (rsData),
        .rtData_o (rtData)
    );

    executeStage executeStage_i (
        .clk        (clk),
        .rst        (rst),
        .ctl_i      (ctl),
        .idEx_i     (idEx),
        .wb_i       (wbReq),
        .exMem_o    (exMem),
        .redirect_o (redirect),
        .target_o   (target)
    );

    memWbStage memWbStage_i (
        .clk           (clk),
        .rst           (rst),
        .ctl_i         (ctl),
        .exMem_i       (exMem),
        .dcacheRdata_i (dcacheRdata_i),
        .dcacheReq_o   (dcacheReq_o),
        .wb_o          (wbReq)
    );

    hazardUnit hazardUnit_i (
        .idEx_i        (idEx),
        .rsAddr_i      (rsAddr),
        .rtAddr_i      (rtAddr),
        .redirect_i    (redirect),
        .icacheStall_i (icacheStall_i),
        .dcacheStall_i (dcacheStall_i),
        .ctl_o         (ctl)
    );

endmodule

`default_nettype wire

//--- src/hazardUnit.sv
`timescale 1ns/10ps
`default_nettype none

module hazardUnit import mipsPkg::*; (
    input  wire idEx_t               idEx_i,
    input  wire logic [RegAddrW-1:0] rsAddr_i,
    input  wire logic [RegAddrW-1:0] rtAddr_i,
    input  wire logic                redirect_i,
    input  wire logic                icacheStall_i,
    input  wire logic                dcacheStall_i,
    output pipeCtl_t                 ctl_o
);

    logic memStall;
    logic loadUse;

    assign memStall = icacheStall_i || dcacheStall_i;

    // Load in EX feeding the instruction being decoded
    assign loadUse = idEx_i.memRead && idEx_i.rd != '0
                     && (idEx_i.rd == rsAddr_i || idEx_i.rd == rtAddr_i);

    always_comb begin
        ctl_o.pcWrite   = 1'b1;
        ctl_o.idWrite   = 1'b1;
        ctl_o.idFlush   = 1'b0;
        ctl_o.exWrite   = 1'b1;
        ctl_o.exFlush   = 1'b0;
        ctl_o.backWrite = 1'b1;

        if (memStall) begin
            // Freeze everything
            ctl_o = '0;
        end else if (redirect_i) begin
            ctl_o.idFlush = 1'b1;
            ctl_o.exFlush = 1'b1;
        end else if (loadUse) begin
            ctl_o.pcWrite = 1'b0;
            ctl_o.idWrite = 1'b0;
            ctl_o.exFlush = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/memWbStage.sv
`timescale 1ns/10ps
`default_nettype none

module memWbStage import mipsPkg::*; (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire pipeCtl_t         ctl_i,
    input  wire exMem_t           exMem_i,
    input  wire logic [DataW-1:0] dcacheRdata_i,
    output dcacheReq_t            dcacheReq_o,
    output wbReq_t                wb_o
);

    logic                regWriteQ;
    logic                memToRegQ;
    logic [RegAddrW-1:0] rdQ;
    logic [DataW-1:0]    loadDataQ;
    logic [DataW-1:0]    aluResQ;

    assign dcacheReq_o.ren   = exMem_i.memRead;
    assign dcacheReq_o.wen   = exMem_i.memWrite;
    assign dcacheReq_o.addr  = exMem_i.aluRes[DataW-1:2];
    assign dcacheReq_o.wdata = exMem_i.storeData;

    // Load data only valid once the data cache drops its stall
    always_ff @(posedge clk) begin
        if (rst) begin
            regWriteQ <= 1'b0;
            memToRegQ <= 1'b0;
            rdQ       <= '0;
            loadDataQ <= '0;
            aluResQ   <= '0;
        end else if (ctl_i.backWrite) begin
            regWriteQ <= exMem_i.regWrite;
            memToRegQ <= exMem_i.memToReg;
            rdQ       <= exMem_i.rd;
            loadDataQ <= dcacheRdata_i;
            aluResQ   <= exMem_i.aluRes;
        end
    end

    assign wb_o.en   = regWriteQ;
    assign wb_o.rd   = rdQ;
    assign wb_o.data = memToRegQ ? loadDataQ : aluResQ;

endmodule

`default_nettype wire

//--- src/executeStage.sv
`timescale 1ns/10ps
`default_nettype none

module executeStage import mipsPkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire pipeCtl_t ctl_i,
    input  wire idEx_t    idEx_i,
    input  wire wbReq_t   wb_i,
    output exMem_t        exMem_o,
    output logic          redirect_o,
    output logic [DataW-1:0] target_o
);

    logic [DataW-1:0] rsFwd;
    logic [DataW-1:0] rtFwd;
    logic [DataW-1:0] opB;
    logic [DataW-1:0] aluRes;
    logic             operandsEq;
    logic             branchTaken;

    // MEM result first, then WB data, then the register value
    function automatic logic [DataW-1:0] forward(
        input logic [RegAddrW-1:0] src,
        input logic [DataW-1:0]    regValue,
        input exMem_t              memReg,
        input wbReq_t              wbReq
    );
        logic [DataW-1:0] value;
        if (memReg.regWrite && memReg.rd != '0 && memReg.rd == src) begin
            value = memReg.aluRes;
        end else if (wbReq.en && wbReq.rd != '0 && wbReq.rd == src) begin
            value = wbReq.data;
        end else begin
            value = regValue;
        end
        return value;
    endfunction

    assign rsFwd = forward(idEx_i.rs, idEx_i.rsData, exMem_o, wb_i);
    assign rtFwd = forward(idEx_i.rt, idEx_i.rtData, exMem_o, wb_i);
    assign opB   = idEx_i.aluSrcImm ? idEx_i.imm : rtFwd;

    always_comb begin
        case (idEx_i.aluCtl)
            AluAdd:  aluRes = rsFwd + opB;
            AluSub:  aluRes = rsFwd - opB;
            AluAnd:  aluRes = rsFwd & opB;
            AluOr:   aluRes = rsFwd | opB;
            AluSlt:  aluRes = {{(DataW-1){1'b0}}, $signed(rsFwd) < $signed(opB)};
            default: aluRes = '0;
        endcase
    end

    // Branch compare on forwarded operands
    assign operandsEq  = rsFwd == rtFwd;
    assign branchTaken = (idEx_i.beq && operandsEq) || (idEx_i.bne && !operandsEq);
    assign redirect_o  = branchTaken || idEx_i.jump;

    // J target was already formed in decode
    assign target_o = idEx_i.jump ? idEx_i.imm
                                  : idEx_i.pcPlus4 + {idEx_i.imm[DataW-3:0], 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            exMem_o <= '0;
        end else if (ctl_i.backWrite) begin
            exMem_o.regWrite  <= idEx_i.regWrite;
            exMem_o.memToReg  <= idEx_i.memToReg;
            exMem_o.memRead   <= idEx_i.memRead;
            exMem_o.memWrite  <= idEx_i.memWrite;
            exMem_o.aluRes    <= aluRes;
            exMem_o.storeData <= rtFwd;
            exMem_o.rd        <= idEx_i.rd;
        end
    end

endmodule

`default_nettype wire

//--- src/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage import mipsPkg::*; (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire pipeCtl_t         ctl_i,
    input  wire ifId_t            ifId_i,
    output logic [RegAddrW-1:0]   rsAddr_o,
    output logic [RegAddrW-1:0]   rtAddr_o,
    input  wire logic [DataW-1:0] rsData_i,
    input  wire logic [DataW-1:0] rtData_i,
    output idEx_t                 idEx_o
);

    instr_t instr;
    idEx_t  idNext;

    assign instr    = ifId_i.instr;
    assign rsAddr_o = instr.r.rs;
    assign rtAddr_o = instr.r.rt;

    always_comb begin
        // Anything not matched below stays a no-op
        idNext         = '0;
        idNext.pcPlus4 = ifId_i.pcPlus4;
        idNext.rs      = instr.r.rs;
        idNext.rt      = instr.r.rt;
        idNext.rd      = instr.i.rt;
        idNext.rsData  = rsData_i;
        idNext.rtData  = rtData_i;
        idNext.imm     = {{16{instr.i.imm16[15]}}, instr.i.imm16};

        case (instr.r.opcode)
            OpRType: begin
                idNext.rd       = instr.r.rd;
                idNext.regWrite = 1'b1;
                case (instr.r.funct)
                    FnAdd:   idNext.aluCtl = AluAdd;
                    FnSub:   idNext.aluCtl = AluSub;
                    FnAnd:   idNext.aluCtl = AluAnd;
                    FnOr:    idNext.aluCtl = AluOr;
                    FnSlt:   idNext.aluCtl = AluSlt;
                    default: idNext.regWrite = 1'b0;
                endcase
            end
            OpAddi: begin
                idNext.regWrite  = 1'b1;
                idNext.aluSrcImm = 1'b1;
                idNext.aluCtl    = AluAdd;
            end
            OpLw: begin
                idNext.regWrite  = 1'b1;
                idNext.memToReg  = 1'b1;
                idNext.memRead   = 1'b1;
                idNext.aluSrcImm = 1'b1;
                idNext.aluCtl    = AluAdd;
            end
            OpSw: begin
                idNext.memWrite  = 1'b1;
                idNext.aluSrcImm = 1'b1;
                idNext.aluCtl    = AluAdd;
            end
            OpBeq: idNext.beq = 1'b1;
            OpBne: idNext.bne = 1'b1;
            OpJ: begin
                idNext.jump = 1'b1;
                // Pseudo-direct target from the upper PC bits
                idNext.imm  = {ifId_i.pcPlus4[31:28], instr.i.rs, instr.i.rt,
                               instr.i.imm16, 2'b00};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idEx_o <= '0;
        end else if (ctl_i.exFlush) begin
            idEx_o <= '0;
        end else if (ctl_i.exWrite) begin
            idEx_o <= idNext;
        end
    end

endmodule

`default_nettype wire

//--- src/fetchStage.sv
`timescale 1ns/10ps
`default_nettype none

module fetchStage import mipsPkg::*; (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire pipeCtl_t         ctl_i,
    input  wire logic             redirect_i,
    input  wire logic [DataW-1:0] target_i,
    input  wire instr_t           instr_i,
    output logic [CacheAddrW-1:0] icacheAddr_o,
    output ifId_t                 ifId_o
);

    logic [DataW-1:0] pc;
    logic [DataW-1:0] pcPlus4;
    logic [DataW-1:0] pcNext;

    assign pcPlus4 = pc + 32'd4;

    // Branch or jump resolved in EX overrides sequential fetch
    assign pcNext = redirect_i ? target_i : pcPlus4;

    // Word address without the byte offset
    assign icacheAddr_o = pc[DataW-1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (ctl_i.pcWrite) begin
            pc <= pcNext;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ifId_o <= '0;
        end else if (ctl_i.idFlush) begin
            ifId_o <= '0;
        end else if (ctl_i.idWrite) begin
            ifId_o.instr   <= instr_i;
            ifId_o.pcPlus4 <= pcPlus4;
        end
    end

endmodule

`default_nettype wire

//--- src/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile import mipsPkg::*; (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic [RegAddrW-1:0] rsAddr_i,
    input  wire logic [RegAddrW-1:0] rtAddr_i,
    input  wire wbReq_t              wb_i,
    output logic [DataW-1:0]         rsData_o,
    output logic [DataW-1:0]         rtData_o
);

    logic [DataW-1:0] regs [NumRegs];

    // Write-first so WB and decode may touch the same register in one cycle
    assign rsData_o = (rsAddr_i == '0) ? '0
                    : (wb_i.en && wb_i.rd == rsAddr_i) ? wb_i.data
                    : regs[rsAddr_i];
    assign rtData_o = (rtAddr_i == '0) ? '0
                    : (wb_i.en && wb_i.rd == rtAddr_i) ? wb_i.data
                    : regs[rtAddr_i];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.en && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

endmodule

`default_nettype wire

//--- src/mipsPkg.sv
`default_nettype none

package mipsPkg;

    localparam int DataW      = 32;
    localparam int RegAddrW   = 5;
    localparam int NumRegs    = 32;
    localparam int CacheAddrW = 30;

    // Primary opcodes
    localparam logic [5:0] OpRType = 6'h00;
    localparam logic [5:0] OpJ     = 6'h02;
    localparam logic [5:0] OpBeq   = 6'h04;
    localparam logic [5:0] OpBne   = 6'h05;
    localparam logic [5:0] OpAddi  = 6'h08;
    localparam logic [5:0] OpLw    = 6'h23;
    localparam logic [5:0] OpSw    = 6'h2b;

    // R-type function codes
    localparam logic [5:0] FnAdd = 6'h20;
    localparam logic [5:0] FnSub = 6'h22;
    localparam logic [5:0] FnAnd = 6'h24;
    localparam logic [5:0] FnOr  = 6'h25;
    localparam logic [5:0] FnSlt = 6'h2a;

    localparam logic [2:0] AluAdd = 3'd0;
    localparam logic [2:0] AluSub = 3'd1;
    localparam logic [2:0] AluAnd = 3'd2;
    localparam logic [2:0] AluOr  = 3'd3;
    localparam logic [2:0] AluSlt = 3'd4;

    // Same word seen as R-format or as I-format
    // The I view also carries the J index
    typedef union packed {
        struct packed {
            logic [5:0]          opcode;
            logic [RegAddrW-1:0] rs;
            logic [RegAddrW-1:0] rt;
            logic [RegAddrW-1:0] rd;
            logic [4:0]          shamt;
            logic [5:0]          funct;
        } r;
        struct packed {
            logic [5:0]          opcode;
            logic [RegAddrW-1:0] rs;
            logic [RegAddrW-1:0] rt;
            logic [15:0]         imm16;
        } i;
    } instr_t;

    typedef struct packed {
        instr_t             instr;
        logic [DataW-1:0]   pcPlus4;
    } ifId_t;

    typedef struct packed {
        logic                regWrite;
        logic                memToReg;
        logic                memRead;
        logic                memWrite;
        logic                aluSrcImm;
        logic                beq;
        logic                bne;
        logic                jump;
        logic [2:0]          aluCtl;
        logic [DataW-1:0]    pcPlus4;
        logic [RegAddrW-1:0] rs;
        logic [RegAddrW-1:0] rt;
        logic [RegAddrW-1:0] rd;
        logic [DataW-1:0]    rsData;
        logic [DataW-1:0]    rtData;
        logic [DataW-1:0]    imm;
    } idEx_t;

    typedef struct packed {
        logic                regWrite;
        logic                memToReg;
        logic                memRead;
        logic                memWrite;
        logic [DataW-1:0]    aluRes;
        logic [DataW-1:0]    storeData;
        logic [RegAddrW-1:0] rd;
    } exMem_t;

    typedef struct packed {
        logic                en;
        logic [RegAddrW-1:0] rd;
        logic [DataW-1:0]    data;
    } wbReq_t;

    typedef struct packed {
        logic                  ren;
        logic                  wen;
        logic [CacheAddrW-1:0] addr;
        logic [DataW-1:0]      wdata;
    } dcacheReq_t;

    typedef struct packed {
        logic pcWrite;
        logic idWrite;
        logic idFlush;
        logic exWrite;
        logic exFlush;
        logic backWrite;
    } pipeCtl_t;

endpackage

`default_nettype wire
